/* verif/eth_bridge_testdata.txt */
// port link speed bad fwd drop len first, all hex, bytes count up from first
// speed 2 is gigabit, drop is the byte where link falls (00 none), port f ends the list
0_1_2_0_1_00_06_10 // short good frame
0_1_2_0_1_00_0c_20
0_1_2_1_0_00_08_30 // bad flag on last byte
0_1_2_0_1_00_05_40
0_0_2_0_0_00_07_50 // link bit clear
0_1_1_0_0_00_07_58 // 100M link
0_1_2_0_0_04_0a_60 // link lost at byte 4
0_1_2_0_1_00_09_70
0_1_2_0_0_00_50_80 // 80 bytes, overflow
0_1_2_0_1_00_10_d0
0_1_2_0_1_00_40_00 // fills the FIFO exactly
0_1_2_0_1_00_03_e0
1_1_2_0_1_00_04_a0
1_1_2_0_1_00_14_11
1_1_0_0_0_00_06_33 // 10M link
1_1_2_1_0_00_0c_44 // bad flag on last byte
1_1_2_0_1_00_07_55
1_1_2_0_0_00_48_66 // 72 bytes, overflow
1_1_2_0_1_00_08_77
1_1_2_0_0_05_06_88 // link lost on the last byte
1_1_2_0_1_00_20_99
1_1_2_0_1_00_01_c0 // single byte frame
f_0_0_0_0_00_00_00 // end of list

/* tb.f */
+incdir+common
common/eth_bridge_pkg.sv
rx_port/rx_frame_filter.sv
frame_fifo/frame_fifo.sv
logic/tx_framer.sv
logic/eth_bridge_top.sv
verif/tb_eth_bridge.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the frame bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module tb_eth_bridge -o tb_eth_bridge
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_eth_bridge
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit "$status"
fi

exit 0

/* verif/tb_eth_bridge.sv */
/*
 * testbench for the two-port frame bridge
 * frames come from the testdata file, both transmit outputs are checked
 */
`timescale 1ns/1ps
`default_nettype none

`include "eth_bridge_cfg.svh"

module tb_eth_bridge;
    import eth_bridge_pkg::*;

    localparam int MAX_REC       = 64;
    localparam int ROOM_TIMEOUT  = 4000;
    localparam int DRAIN_TIMEOUT = 8000;

    logic        clk20_g;
    logic        arst_n_i;
    logic        rx_valid_i [`PORT_COUNT];
    rx_beat_t    rx_beat_i  [`PORT_COUNT];
    mac_status_t status_i   [`PORT_COUNT];
    logic        tx_valid_o [`PORT_COUNT];
    tx_beat_t    tx_beat_o  [`PORT_COUNT];
    logic        tx_ready_i [`PORT_COUNT];
    logic        overflow_o [`PORT_COUNT];

    // one record per frame, layout as in the data file header
    logic [43:0] testdata [MAX_REC];
    int          rec_count;

    // expected beats per output port, name of the owning frame alongside
    tx_beat_t    exp_q    [`PORT_COUNT][$];
    string       name_q   [`PORT_COUNT][$];
    int          ovf_exp  [`PORT_COUNT];
    int          ovf_seen [`PORT_COUNT];
    logic [15:0] lfsr_q;

    eth_bridge_top u_dut (
        .clk20_g    (clk20_g),
        .arst_n_i   (arst_n_i),
        .rx_valid_i (rx_valid_i),
        .rx_beat_i  (rx_beat_i),
        .status_i   (status_i),
        .tx_valid_o (tx_valid_o),
        .tx_beat_o  (tx_beat_o),
        .tx_ready_i (tx_ready_i),
        .overflow_o (overflow_o)
    );

    initial begin
        clk20_g = 1'b0;
        forever #20 clk20_g = ~clk20_g;
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    task automatic report_failure();
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_beat(input string test, input tx_beat_t exp, input tx_beat_t act);
        if (exp !== act) begin
            $display("Mismatch %0s: expected data %h sof %b last %b, actual data %h sof %b last %b",
                     test, exp.data, exp.sof, exp.last, act.data, act.sof, act.last);
            report_failure();
        end
    endtask

    task automatic check_logic(input string test, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Mismatch %0s: expected %b, actual %b", test, exp, act);
            report_failure();
        end
    endtask

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end else begin
            return s >> 1;
        end
    endfunction

    task automatic check_quiet(input string test);
        int p;
        for (p = 0; p < `PORT_COUNT; p++) begin
            check_logic({test, " tx_valid"}, 1'b0, tx_valid_o[p]);
            check_logic({test, " overflow"}, 1'b0, overflow_o[p]);
        end
    endtask

    task automatic load_testdata();
        int r;
        rec_count = -1;
        $readmemh("verif/eth_bridge_testdata.txt", testdata);
        // port field f ends the list
        for (r = 0; r < MAX_REC; r++) begin
            if (rec_count < 0 && testdata[r][43:40] === 4'hf) begin
                rec_count = r;
            end
        end
        if (rec_count < 0) begin
            $display("test data has no end record");
            report_failure();
        end
    endtask

    task automatic wait_for_room(input int dst, input int need);
        int waited;
        waited = 0;
        while (exp_q[dst].size() + need > `FIFO_DEPTH) begin
            @(posedge clk20_g);
            waited++;
            if (waited > ROOM_TIMEOUT) begin
                $display("timed out waiting for room on the path to port %0d", dst);
                report_failure();
            end
        end
    endtask

    // --------------------------------------------------
    // receive drivers
    // --------------------------------------------------
    task automatic drive_port(input int p);
        int          r;
        int          i;
        int          dst;
        int          len;
        int          drop;
        logic [43:0] rec;
        string       test;
        tx_beat_t    beat;
        dst = (p + 1) % `PORT_COUNT;
        for (r = 0; r < rec_count; r++) begin
            rec = testdata[r];
            if (int'(rec[43:40]) == p) begin
                len  = int'(rec[15:8]);
                drop = int'(rec[23:16]);
                test = $sformatf("frame %0d on port %0d", r, p);
                // keep the FIFO from filling through slow drain alone
                wait_for_room(dst, (len > `FIFO_DEPTH) ? `FIFO_DEPTH : len);
                if (rec[27:24] != 4'h0) begin
                    for (i = 0; i < len; i++) begin
                        beat.data = rec[7:0] + 8'(i);
                        beat.sof  = (i == 0);
                        beat.last = (i == len - 1);
                        exp_q[dst].push_back(beat);
                        name_q[dst].push_back(test);
                    end
                end
                // accepted but oversized, one overflow pulse
                if (rec[39:36] == 4'h1 && rec[33:32] == 2'd2 && drop == 0
                    && len > `FIFO_DEPTH) begin
                    ovf_exp[p]++;
                end
                for (i = 0; i < len; i++) begin
                    @(posedge clk20_g);
                    #1;
                    rx_valid_i[p]     = 1'b1;
                    rx_beat_i[p].data = rec[7:0] + 8'(i);
                    rx_beat_i[p].last = (i == len - 1);
                    rx_beat_i[p].bad  = rec[28] && (i == len - 1);
                    status_i[p].spare = 1'b0;
                    status_i[p].speed = link_speed_e'(rec[33:32]);
                    // link falls at byte drop and stays down
                    status_i[p].link  = rec[36] && !(drop != 0 && i >= drop);
                end
                @(posedge clk20_g);
                #1;
                rx_valid_i[p] = 1'b0;
            end
        end
    endtask

    // --------------------------------------------------
    // output monitors, sampled mid-cycle
    // --------------------------------------------------
    task automatic watch_port(input int p);
        tx_beat_t held;
        logic     holding;
        int       gap_left;
        holding  = 1'b0;
        gap_left = 0;
        forever begin
            @(negedge clk20_g);
            if (gap_left > 0) begin
                check_logic($sformatf("inter-frame gap on port %0d", p), 1'b0, tx_valid_o[p]);
                gap_left--;
            end
            if (holding) begin
                check_logic($sformatf("valid held on port %0d", p), 1'b1, tx_valid_o[p]);
                check_beat($sformatf("beat held on port %0d", p), held, tx_beat_o[p]);
            end
            holding = tx_valid_o[p] && !tx_ready_i[p];
            held    = tx_beat_o[p];
            if (tx_valid_o[p] && tx_ready_i[p]) begin
                if (exp_q[p].size() == 0) begin
                    $display("port %0d sent a byte that no frame accounts for", p);
                    report_failure();
                end
                check_beat(name_q[p].pop_front(), exp_q[p].pop_front(), tx_beat_o[p]);
                if (tx_beat_o[p].last) begin
                    gap_left = `IFG_CYCLES;
                end
            end
        end
    endtask

    task automatic watch_overflow(input int p);
        forever begin
            @(negedge clk20_g);
            if (overflow_o[p]) begin
                // high only while an oversized frame is still owed a pulse
                check_logic($sformatf("overflow on port %0d", p),
                            ovf_seen[p] < ovf_exp[p], overflow_o[p]);
                ovf_seen[p]++;
            end
        end
    endtask

    // ready pattern, one lfsr step per port per cycle
    initial begin
        lfsr_q = 16'd35;
        forever begin
            @(posedge clk20_g);
            #1;
            for (int p = 0; p < `PORT_COUNT; p++) begin
                lfsr_q        = lfsr_next(lfsr_q);
                tx_ready_i[p] = lfsr_q[0];
            end
        end
    end

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        int   waited;
        logic count_ok;
        arst_n_i = 1'b0;
        for (int p = 0; p < `PORT_COUNT; p++) begin
            rx_valid_i[p] = 1'b0;
            rx_beat_i[p]  = '0;
            status_i[p]   = '0;
            tx_ready_i[p] = 1'b0;
            ovf_exp[p]    = 0;
            ovf_seen[p]   = 0;
        end
        load_testdata();
        fork
            watch_port(0);
            watch_port(1);
            watch_overflow(0);
            watch_overflow(1);
        join_none

        repeat (8) begin
            @(negedge clk20_g);
            check_quiet("during reset");
        end
        @(posedge clk20_g);
        #1;
        arst_n_i = 1'b1;
        repeat (4) begin
            @(negedge clk20_g);
            check_quiet("after reset");
        end

        fork
            drive_port(0);
            drive_port(1);
        join

        // both directions drain
        waited = 0;
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
            @(posedge clk20_g);
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                $display("timed out waiting for the expected frames to leave the bridge");
                report_failure();
            end
        end
        // let the last gap check run out
        repeat (`IFG_CYCLES + 2) @(negedge clk20_g);

        count_ok = 1'b1;
        for (int p = 0; p < `PORT_COUNT; p++) begin
            if (ovf_seen[p] != ovf_exp[p]) begin
                $display("Mismatch overflow count on port %0d: expected %0d, actual %0d",
                         p, ovf_exp[p], ovf_seen[p]);
                count_ok = 1'b0;
            end
        end
        if (count_ok) begin
            $display("Testbench passed");
            $finish;
        end else begin
            report_failure();
        end
    end

endmodule

`default_nettype wire

/* logic/eth_bridge_top.sv */
/*
 * two-port frame bridge top
 * each port's receive path ends on the opposite port's transmit output
 */
`timescale 1ns/1ps
`default_nettype none

`include "eth_bridge_cfg.svh"

module eth_bridge_top (
    input  wire logic                        clk20_g,
    input  wire logic                        arst_n_i,
    input  wire logic                        rx_valid_i [`PORT_COUNT],
    input  wire eth_bridge_pkg::rx_beat_t    rx_beat_i  [`PORT_COUNT],
    input  wire eth_bridge_pkg::mac_status_t status_i   [`PORT_COUNT],
    output logic                             tx_valid_o [`PORT_COUNT],
    output eth_bridge_pkg::tx_beat_t         tx_beat_o  [`PORT_COUNT],
    input  wire logic                        tx_ready_i [`PORT_COUNT],
    output logic                             overflow_o [`PORT_COUNT]
);
    import eth_bridge_pkg::*;

    // --------------------------------------------------
    // one path per receive port
    // --------------------------------------------------
    for (genvar p = 0; p < `PORT_COUNT; p++) begin : g_path
        // transmit port on the far side
        localparam int DST = (p + 1) % `PORT_COUNT;

        logic       filt_valid;
        rx_beat_t   filt_beat;
        logic       fifo_valid;
        fifo_beat_t fifo_beat;
        logic       fifo_ready;

        rx_frame_filter u_filter (
            .clk20_g    (clk20_g),
            .arst_n_i   (arst_n_i),
            .rx_valid_i (rx_valid_i[p]),
            .rx_beat_i  (rx_beat_i[p]),
            .status_i   (status_i[p]),
            .valid_o    (filt_valid),
            .beat_o     (filt_beat)
        );

        // overflow reported on the receiving port
        frame_fifo u_fifo (
            .clk20_g    (clk20_g),
            .arst_n_i   (arst_n_i),
            .wr_valid_i (filt_valid),
            .wr_beat_i  (filt_beat),
            .rd_valid_o (fifo_valid),
            .rd_beat_o  (fifo_beat),
            .rd_ready_i (fifo_ready),
            .overflow_o (overflow_o[p])
        );

        // crossed here
        tx_framer u_framer (
            .clk20_g    (clk20_g),
            .arst_n_i   (arst_n_i),
            .in_valid_i (fifo_valid),
            .in_beat_i  (fifo_beat),
            .in_ready_o (fifo_ready),
            .tx_valid_o (tx_valid_o[DST]),
            .tx_beat_o  (tx_beat_o[DST]),
            .tx_ready_i (tx_ready_i[DST])
        );
    end

endmodule

`default_nettype wire

/* logic/tx_framer.sv */
/*
 * transmit side, marks start of frame and spaces frames apart
 * sits between the frame FIFO and the outgoing MAC stream
 */
`timescale 1ns/1ps
`default_nettype none

`include "eth_bridge_cfg.svh"

module tx_framer (
    input  wire logic                       clk20_g,
    input  wire logic                       arst_n_i,
    input  wire logic                       in_valid_i,
    input  wire eth_bridge_pkg::fifo_beat_t in_beat_i,
    output logic                            in_ready_o,
    output logic                            tx_valid_o,
    output eth_bridge_pkg::tx_beat_t        tx_beat_o,
    input  wire logic                       tx_ready_i
);
    import eth_bridge_pkg::*;

    localparam int GAP_W = $clog2(`IFG_CYCLES + 1);

    tx_state_e        state_q;
    logic [GAP_W-1:0] gap_q;
    logic             open_w;
    logic             fire_w;

    // FIFO held off during the gap
    assign open_w     = (state_q != TX_GAP);
    assign tx_valid_o = in_valid_i && open_w;
    assign in_ready_o = tx_ready_i && open_w;
    assign fire_w     = tx_valid_o && tx_ready_i;

    // sof only while waiting for a first byte
    always_comb begin
        tx_beat_o.data = in_beat_i.data;
        tx_beat_o.sof  = (state_q == TX_IDLE);
        tx_beat_o.last = in_beat_i.last;
    end

    always_ff @(posedge clk20_g or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= TX_IDLE;
            gap_q   <= '0;
        end else begin
            case (state_q)
                TX_IDLE, TX_SEND: begin
                    if (fire_w) begin
                        if (in_beat_i.last) begin
                            state_q <= TX_GAP;
                            gap_q   <= GAP_W'(`IFG_CYCLES - 1);
                        end else begin
                            state_q <= TX_SEND;
                        end
                    end
                end
                TX_GAP: begin
                    // count down idle cycles
                    if (gap_q == '0) begin
                        state_q <= TX_IDLE;
                    end else begin
                        gap_q <= gap_q - 1'b1;
                    end
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    // beat held under back-pressure, relies on the FIFO output too
    a_hold_stable: assert property (
        @(posedge clk20_g) disable iff (!arst_n_i)
        tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_beat_o)
    );

endmodule

`default_nettype wire

/* frame_fifo/frame_fifo.sv */
/*
 * store-and-forward frame FIFO
 * only whole good frames become readable, bad or oversized frames are rewound
 */
`timescale 1ns/1ps
`default_nettype none

`include "eth_bridge_cfg.svh"

module frame_fifo (
    input  wire logic                      clk20_g,
    input  wire logic                      arst_n_i,
    input  wire logic                      wr_valid_i,
    input  wire eth_bridge_pkg::rx_beat_t  wr_beat_i,
    output logic                           rd_valid_o,
    output eth_bridge_pkg::fifo_beat_t     rd_beat_o,
    input  wire logic                      rd_ready_i,
    output logic                           overflow_o
);
    import eth_bridge_pkg::*;

    localparam int AW    = $clog2(`FIFO_DEPTH);
    // one extra bit tells full from empty
    localparam int PTR_W = AW + 1;

    fifo_beat_t mem [`FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] commit_ptr_q;
    logic [PTR_W-1:0] commit_rd_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic             drop_q;
    logic [PTR_W-1:0] used_w;
    logic             full_w;
    logic             wr_fit_w;
    logic             rd_fire_w;

    // space counted against read side, uncommitted bytes included
    assign used_w    = wr_ptr_q - rd_ptr_q;
    assign full_w    = (used_w == PTR_W'(`FIFO_DEPTH));
    assign wr_fit_w  = wr_valid_i && !drop_q && !full_w;
    assign rd_fire_w = rd_valid_o && rd_ready_i;

    // --------------------------------------------------
    // write side
    // --------------------------------------------------
    always_ff @(posedge clk20_g) begin
        if (wr_fit_w) begin
            mem[wr_ptr_q[AW-1:0]] <= '{data: wr_beat_i.data, last: wr_beat_i.last};
        end
    end

    always_ff @(posedge clk20_g or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q     <= '0;
            commit_ptr_q <= '0;
            drop_q       <= 1'b0;
            overflow_o   <= 1'b0;
        end else begin
            overflow_o <= 1'b0;
            if (wr_valid_i) begin
                if (wr_beat_i.last) begin
                    drop_q <= 1'b0;
                    if (wr_beat_i.bad || drop_q || full_w) begin
                        // rewind to the last good frame
                        wr_ptr_q   <= commit_ptr_q;
                        overflow_o <= drop_q || full_w;
                    end else begin
                        wr_ptr_q     <= wr_ptr_q + 1'b1;
                        commit_ptr_q <= wr_ptr_q + 1'b1;
                    end
                end else if (drop_q || full_w) begin
                    // out of room, ignore rest of frame
                    drop_q <= 1'b1;
                end else begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
            end
        end
    end

    // --------------------------------------------------
    // read side
    // --------------------------------------------------
    always_ff @(posedge clk20_g or negedge arst_n_i) begin
        if (!arst_n_i) begin
            commit_rd_q <= '0;
            rd_ptr_q    <= '0;
        end else begin
            // second stage, frame readable two cycles after its last byte
            commit_rd_q <= commit_ptr_q;
            if (rd_fire_w) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    assign rd_valid_o = (rd_ptr_q != commit_rd_q);
    // entries at or past rd_ptr are never rewritten while committed
    assign rd_beat_o  = mem[rd_ptr_q[AW-1:0]];

    // read side stays behind the committed frames
    a_rd_behind_commit: assert property (
        @(posedge clk20_g) disable iff (!arst_n_i)
        (commit_ptr_q - rd_ptr_q) <= PTR_W'(`FIFO_DEPTH)
    );

endmodule

`default_nettype wire

/* rx_port/rx_frame_filter.sv */
/*
 * receive qualifier, one per port
 * drops frames started without gigabit link, closes frames cut by link loss
 */
`timescale 1ns/1ps
`default_nettype none

module rx_frame_filter (
    input  wire logic                   clk20_g,
    input  wire logic                   arst_n_i,
    input  wire logic                   rx_valid_i,
    input  wire eth_bridge_pkg::rx_beat_t    rx_beat_i,
    input  wire eth_bridge_pkg::mac_status_t status_i,
    output logic                        valid_o,
    output eth_bridge_pkg::rx_beat_t    beat_o
);
    import eth_bridge_pkg::*;

    rx_state_e state_q;
    rx_state_e state_d;
    logic      emit_d;
    rx_beat_t  beat_d;
    logic      link_up_w;

    // usable only with link set at gigabit
    assign link_up_w = status_i.link && (status_i.speed == SPEED_1G);

    // --------------------------------------------------
    // frame tracking
    // --------------------------------------------------
    always_comb begin
        state_d = state_q;
        emit_d  = 1'b0;
        beat_d  = rx_beat_i;
        case (state_q)
            RX_IDLE: begin
                // link sampled on first byte only
                if (rx_valid_i) begin
                    if (link_up_w) begin
                        emit_d = 1'b1;
                        if (!rx_beat_i.last) begin
                            state_d = RX_FRAME;
                        end
                    end else if (!rx_beat_i.last) begin
                        state_d = RX_DISCARD;
                    end
                end
            end
            RX_FRAME: begin
                if (!link_up_w) begin
                    // link lost mid-frame, close it as bad
                    emit_d      = 1'b1;
                    beat_d.last = 1'b1;
                    beat_d.bad  = 1'b1;
                    if (rx_valid_i && rx_beat_i.last) begin
                        state_d = RX_IDLE;
                    end else begin
                        state_d = RX_DISCARD;
                    end
                end else if (rx_valid_i) begin
                    emit_d = 1'b1;
                    if (rx_beat_i.last) begin
                        state_d = RX_IDLE;
                    end
                end
            end
            RX_DISCARD: begin
                // swallow bytes up to the end of frame
                if (rx_valid_i && rx_beat_i.last) begin
                    state_d = RX_IDLE;
                end
            end
            default: state_d = RX_IDLE;
        endcase
    end

    always_ff @(posedge clk20_g or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= RX_IDLE;
            valid_o <= 1'b0;
        end else begin
            state_q <= state_d;
            valid_o <= emit_d;
        end
    end

    // payload stage, one cycle behind the input
    always_ff @(posedge clk20_g) begin
        if (emit_d) begin
            beat_o <= beat_d;
        end
    end

    // in discard only the closing bad beat may still be leaving
    a_no_valid_in_discard: assert property (
        @(posedge clk20_g) disable iff (!arst_n_i)
        state_q == RX_DISCARD |-> !valid_o || (beat_o.last && beat_o.bad)
    );

endmodule

`default_nettype wire

/* common/eth_bridge_pkg.sv */
/*
 * shared types for the two-port frame bridge
 * import in module bodies, scoped names in port lists
 */
`default_nettype none

`include "eth_bridge_cfg.svh"

package eth_bridge_pkg;

    // speed code from the MAC status, 2 means gigabit
    typedef enum logic [1:0] {
        SPEED_10M  = 2'd0,
        SPEED_100M = 2'd1,
        SPEED_1G   = 2'd2
    } link_speed_e;

    // bit 0 link, bits 2:1 speed, bit 3 spare
    typedef struct packed {
        logic        spare;
        link_speed_e speed;
        logic        link;
    } mac_status_t;

    // receive byte from the MAC, no ready on this side
    typedef struct packed {
        logic [`BYTE_W-1:0] data;
        logic               last;
        logic               bad;
    } rx_beat_t;

    // transmit byte toward the MAC
    typedef struct packed {
        logic [`BYTE_W-1:0] data;
        logic               sof;
        logic               last;
    } tx_beat_t;

    // frame FIFO entry
    typedef struct packed {
        logic [`BYTE_W-1:0] data;
        logic               last;
    } fifo_beat_t;

    typedef enum logic [1:0] {RX_IDLE, RX_FRAME, RX_DISCARD} rx_state_e;

    typedef enum logic [1:0] {TX_IDLE, TX_SEND, TX_GAP} tx_state_e;

endpackage

`default_nettype wire

/* common/eth_bridge_cfg.svh */
/*
 * build-time sizes for the frame bridge
 * include wherever a size is needed
 */
`ifndef ETH_BRIDGE_CFG_SVH
`define ETH_BRIDGE_CFG_SVH

// byte lane width
`define BYTE_W 8

// frame FIFO size in bytes
`define FIFO_DEPTH 64

// idle cycles after every sent frame
`define IFG_CYCLES 12

// number of bridged ports
`define PORT_COUNT 2

`endif
